// ==== include/tnn_config.svh ====
`ifndef TNN_CONFIG_SVH
`define TNN_CONFIG_SVH

// **************************************************
// network shape
// **************************************************

`define TNN_FEAT_CNT    11  // input features per sample.
`define TNN_FEAT_BITS   4   // unsigned bits per feature.
`define TNN_HIDDEN_CNT  40
`define TNN_CLASS_CNT   6

// **************************************************
// datapath widths
// **************************************************

// 11 features of at most 15 each, so sums stay within +/-165.
`define TNN_ACC_BITS    9
// two times popcount plus bias peaks at 36.
`define TNN_SCORE_BITS  7
`define TNN_COUNT_BITS  16

// input register, hidden, scores, argmax.
`define TNN_STAGES      4

`endif

// ==== rtl/tnn_pkg.sv ====
`include "tnn_config.svh"

package tnn_pkg;

    // **************************************************
    // datapath types
    // **************************************************

    typedef logic [`TNN_FEAT_BITS-1:0] feature_t;
    typedef feature_t [`TNN_FEAT_CNT-1:0] feature_vec_t;  // feature 0 in the low bits.

    typedef logic [`TNN_HIDDEN_CNT-1:0] hidden_vec_t;

    typedef logic [`TNN_SCORE_BITS-1:0] score_t;
    typedef score_t [`TNN_CLASS_CNT-1:0] score_vec_t;     // class 0 in the low bits.

    typedef logic [$clog2(`TNN_CLASS_CNT)-1:0] class_t;
    typedef logic [`TNN_COUNT_BITS-1:0] count_t;

    // register enables, one per pipeline stage.
    typedef struct packed {
        logic feat_en;
        logic hidden_en;
        logic score_en;
        logic class_en;
    } stage_en_t;

    // **************************************************
    // hidden layer weights
    // **************************************************

    // row per neuron, column per feature, feature 0 first.
    localparam int HIDDEN_W [`TNN_HIDDEN_CNT][`TNN_FEAT_CNT] = '{
        '{-1, -1,  1, -1, -1,  1, -1, -1,  0,  1,  0},  // neuron 0.
        '{-1,  0,  0, -1,  0, -1,  1,  0,  1,  0, -1},
        '{ 0, -1,  0,  0, -1, -1,  0,  0,  0, -1,  0},
        '{ 0,  0,  0,  0,  1, -1,  1,  0,  1,  0, -1},
        '{ 0,  1,  1,  0,  1, -1,  0, -1, -1, -1, -1},
        '{-1,  1,  1,  0,  0,  1,  1, -1, -1,  1,  0},
        '{ 0, -1,  0, -1,  0,  0, -1,  0,  0, -1,  0},
        '{-1,  0,  1,  0, -1, -1, -1,  1,  0,  0,  1},
        '{-1,  1,  1,  1,  1,  0,  1,  0,  0, -1, -1},
        '{ 1,  1,  1,  1,  0, -1,  0,  0,  0,  0,  1},
        '{ 0, -1, -1,  0,  0,  0, -1, -1,  0,  1,  0},  // neuron 10.
        '{ 0, -1, -1,  0,  0, -1, -1, -1,  0,  0,  1},
        '{ 0,  1, -1,  0,  0, -1,  0, -1,  0, -1,  1},
        '{ 1, -1,  1,  0,  0,  1,  1,  0,  1, -1,  1},
        '{ 0,  1,  1,  1, -1,  1,  1,  1,  0,  0,  0},
        '{ 0,  1,  0,  0,  0,  0,  1,  0, -1, -1,  0},
        '{ 0, -1, -1, -1,  0, -1,  0,  1, -1,  0,  1},
        '{ 1,  0,  1,  0, -1, -1,  1,  0,  0,  1, -1},
        '{ 0,  0,  1,  0, -1,  1,  1,  1,  1,  0,  1},
        '{-1,  0,  0,  0,  0,  1, -1,  1, -1, -1,  1},
        '{-1,  0, -1,  0,  0,  0,  0,  1,  0,  1,  0},  // neuron 20.
        '{-1,  0,  0,  1, -1,  1,  0,  0, -1, -1, -1},
        '{ 1, -1,  0,  0,  1,  0,  1,  0,  0,  1,  1},
        '{ 1, -1,  1, -1, -1,  1, -1,  0,  1,  0,  0},
        '{ 0,  0,  1, -1,  1,  1,  0,  1, -1, -1, -1},
        '{ 0, -1,  0,  1,  0,  1, -1,  0, -1,  0,  1},
        '{ 1, -1,  1,  1, -1,  1,  0, -1,  1, -1, -1},
        '{ 1,  0, -1,  0,  1,  0, -1,  0,  0,  0,  1},
        '{ 0,  1,  1,  0,  0,  0, -1,  1,  0, -1,  0},
        '{ 1,  1, -1,  0,  1,  0,  1,  0,  0, -1,  0},
        '{ 1,  0,  1,  0,  0, -1, -1, -1,  1, -1,  1},  // neuron 30.
        '{ 0, -1,  0,  1,  0,  0,  0,  1,  0, -1, -1},
        '{ 1, -1,  1,  1,  0,  1,  0, -1,  1,  0,  1},
        '{-1,  0, -1, -1, -1,  0,  1,  0,  0,  1,  1},
        '{ 1,  0, -1,  0,  0,  0,  1,  0, -1, -1, -1},
        '{ 1,  0, -1, -1,  0,  1, -1, -1, -1,  1,  0},
        '{ 1, -1,  0,  1,  1, -1,  0, -1,  0,  0,  0},
        '{ 0, -1,  0,  0, -1,  0,  0,  0,  0,  0,  0},
        '{ 1,  1,  0,  1,  1,  0,  1,  1, -1,  0,  0},
        '{ 0,  0, -1,  0,  0,  1,  1,  1, -1, -1, -1}
    };

    // **************************************************
    // output layer connections
    // **************************************************

    // hidden bits a class counts when set.
    localparam hidden_vec_t OUT_POS [`TNN_CLASS_CNT] = '{
        40'h80_5040_0014,
        40'h08_2000_2E00,
        40'h02_0000_6110,
        40'h03_0080_0040,
        40'h33_0040_4884,
        40'h2A_4200_2040
    };

    // hidden bits a class counts when clear.
    localparam hidden_vec_t OUT_NEG [`TNN_CLASS_CNT] = '{
        40'h00_2486_1009,
        40'h00_1000_0020,
        40'h08_0200_1203,
        40'h84_0000_1002,
        40'h00_A210_900B,
        40'h00_0000_5111
    };

    localparam score_t OUT_BIAS [`TNN_CLASS_CNT] = '{
        7'd4, 7'd10, 7'd7, 7'd10, 7'd0, 7'd6
    };

endpackage

// ==== rtl/tnn_ctrl.sv ====
`timescale 1ns/1ps
`include "tnn_config.svh"

module tnn_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    output tnn_pkg::stage_en_t  stage_en,
    output logic                out_valid,
    output tnn_pkg::count_t     result_count
);

    logic [`TNN_STAGES-1:0] valid_pipe;  // bit i set once stage i holds an item.

    // **************************************************
    // valid pipeline
    // **************************************************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[`TNN_STAGES-2:0], in_valid};
        end
    end

    // each register loads on the valid of the stage before it.
    assign stage_en.feat_en   = in_valid;
    assign stage_en.hidden_en = valid_pipe[0];
    assign stage_en.score_en  = valid_pipe[1];
    assign stage_en.class_en  = valid_pipe[2];

    assign out_valid = valid_pipe[`TNN_STAGES-1];

    // counts on the edge that raises out_valid, wraps at max.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_count <= '0;
        end else if (valid_pipe[`TNN_STAGES-2]) begin
            result_count <= result_count + 1'b1;
        end
    end

endmodule

// ==== rtl/tnn_hidden_layer.sv ====
`timescale 1ns/1ps
`include "tnn_config.svh"

module tnn_hidden_layer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  en,
    input  tnn_pkg::feature_vec_t features,
    output tnn_pkg::hidden_vec_t  hidden
);

    typedef logic signed [`TNN_ACC_BITS-1:0] acc_t;

    tnn_pkg::hidden_vec_t hidden_nxt;

    // **************************************************
    // ternary neurons
    // **************************************************

    for (genvar n = 0; n < `TNN_HIDDEN_CNT; n++) begin : g_neuron
        acc_t acc;

        always_comb begin
            acc = '0;
            for (int f = 0; f < `TNN_FEAT_CNT; f++) begin
                if (tnn_pkg::HIDDEN_W[n][f] > 0) begin
                    acc = acc + acc_t'(features[f]);
                end else if (tnn_pkg::HIDDEN_W[n][f] < 0) begin
                    acc = acc - acc_t'(features[f]);
                end
            end
        end

        assign hidden_nxt[n] = (acc >= 0);  // sign threshold.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hidden <= '0;
        end else if (en) begin
            hidden <= hidden_nxt;
        end
    end

endmodule

// ==== rtl/tnn_output_layer.sv ====
`timescale 1ns/1ps
`include "tnn_config.svh"

module tnn_output_layer (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 en,
    input  tnn_pkg::hidden_vec_t hidden,
    output tnn_pkg::score_vec_t  scores
);

    tnn_pkg::score_vec_t scores_nxt;

    // **************************************************
    // class scoring
    // **************************************************

    for (genvar c = 0; c < `TNN_CLASS_CNT; c++) begin : g_class
        tnn_pkg::hidden_vec_t match;
        logic [`TNN_SCORE_BITS-2:0] ones;

        // pos and neg masks never overlap.
        assign match = (hidden & tnn_pkg::OUT_POS[c]) | (~hidden & tnn_pkg::OUT_NEG[c]);
        assign ones  = (`TNN_SCORE_BITS-1)'($countones(match));

        assign scores_nxt[c] = {ones, 1'b0} + tnn_pkg::OUT_BIAS[c];  // 2*count + bias.
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scores <= '0;
        end else if (en) begin
            scores <= scores_nxt;
        end
    end

endmodule

// ==== rtl/tnn_argmax.sv ====
`timescale 1ns/1ps
`include "tnn_config.svh"

module tnn_argmax (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                en,
    input  tnn_pkg::score_vec_t scores,
    output tnn_pkg::class_t     prediction
);

    tnn_pkg::score_t best;
    tnn_pkg::class_t best_idx;

    // strict compare, so the first maximum stays.
    always_comb begin
        best     = scores[0];
        best_idx = '0;
        for (int c = 1; c < `TNN_CLASS_CNT; c++) begin
            if (scores[c] > best) begin
                best     = scores[c];
                best_idx = tnn_pkg::class_t'(c);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prediction <= '0;
        end else if (en) begin
            prediction <= best_idx;
        end
    end

endmodule

// ==== rtl/tnn_classifier_top.sv ====
`timescale 1ns/1ps

module tnn_classifier_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  tnn_pkg::feature_vec_t features,
    output logic                  out_valid,
    output tnn_pkg::class_t       prediction,
    output tnn_pkg::count_t       result_count
);

    tnn_pkg::stage_en_t    stage_en;
    tnn_pkg::feature_vec_t feat_q;
    tnn_pkg::hidden_vec_t  hidden;
    tnn_pkg::score_vec_t   scores;

    tnn_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .stage_en     (stage_en),
        .out_valid    (out_valid),
        .result_count (result_count)
    );

    // input register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            feat_q <= '0;
        end else if (stage_en.feat_en) begin
            feat_q <= features;
        end
    end

    // **************************************************
    // datapath stages
    // **************************************************

    tnn_hidden_layer u_hidden (
        .clk      (clk),
        .arst_n   (arst_n),
        .en       (stage_en.hidden_en),
        .features (feat_q),
        .hidden   (hidden)
    );

    tnn_output_layer u_output (
        .clk    (clk),
        .arst_n (arst_n),
        .en     (stage_en.score_en),
        .hidden (hidden),
        .scores (scores)
    );

    tnn_argmax u_argmax (
        .clk        (clk),
        .arst_n     (arst_n),
        .en         (stage_en.class_en),
        .scores     (scores),
        .prediction (prediction)
    );

endmodule

// ==== bench/tnn_classifier_sva.sv ====
`timescale 1ns/1ps
`include "tnn_config.svh"

module tnn_classifier_sva (
    input logic               clk,
    input logic               arst_n,
    input logic               in_valid,
    input tnn_pkg::stage_en_t stage_en,
    input logic               out_valid,
    input tnn_pkg::count_t    result_count
);

    // **************************************************
    // pipeline control properties
    // **************************************************

    property p_latency;
        @(posedge clk) disable iff (!arst_n)
            out_valid == $past(in_valid, `TNN_STAGES);
    endproperty

    property p_count_step;  // counter moves only while a result leaves.
        @(posedge clk) disable iff (!arst_n)
            (result_count != $past(result_count)) |-> out_valid;
    endproperty

    property p_enables_known;
        @(posedge clk) disable iff (!arst_n)
            !$isunknown(stage_en);
    endproperty

    a_latency: assert property (p_latency)
        else $error("out_valid does not follow in_valid by the pipeline depth.");
    a_count_step: assert property (p_count_step)
        else $error("result_count changed without out_valid.");
    a_enables_known: assert property (p_enables_known)
        else $error("stage_en holds an unknown value.");

endmodule

bind tnn_ctrl tnn_classifier_sva u_sva (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .stage_en     (stage_en),
    .out_valid    (out_valid),
    .result_count (result_count)
);

// ==== bench/tnn_classifier_tb.sv ====
`timescale 1ns/1ps
`include "tnn_config.svh"

module tnn_classifier_tb;

    localparam int WAIT_LIMIT = 100;

    logic                  clk;
    logic                  arst_n;
    logic                  in_valid;
    tnn_pkg::feature_vec_t features;
    logic                  out_valid;
    tnn_pkg::class_t       prediction;
    tnn_pkg::count_t       result_count;

    tnn_pkg::class_t expected_q [$];  // predictions still in flight, oldest first.
    tnn_pkg::class_t exp_cls;
    int              n_sent;

    tnn_classifier_top DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .features     (features),
        .out_valid    (out_valid),
        .prediction   (prediction),
        .result_count (result_count)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    // **************************************************
    // reference model
    // **************************************************

    function automatic tnn_pkg::hidden_vec_t model_hidden(input tnn_pkg::feature_vec_t f);
        tnn_pkg::hidden_vec_t h;
        int sum;
        for (int n = 0; n < `TNN_HIDDEN_CNT; n++) begin
            sum = 0;
            for (int i = 0; i < `TNN_FEAT_CNT; i++) begin
                sum += tnn_pkg::HIDDEN_W[n][i] * int'(f[i]);
            end
            h[n] = (sum >= 0);
        end
        return h;
    endfunction

    function automatic int class_score(input tnn_pkg::hidden_vec_t h, input int c);
        int cnt;
        cnt = 0;
        for (int n = 0; n < `TNN_HIDDEN_CNT; n++) begin
            if (tnn_pkg::OUT_POS[c][n] && h[n]) begin
                cnt++;
            end else if (tnn_pkg::OUT_NEG[c][n] && !h[n]) begin
                cnt++;
            end
        end
        return 2 * cnt + int'(tnn_pkg::OUT_BIAS[c]);
    endfunction

    function automatic tnn_pkg::class_t predict(input tnn_pkg::feature_vec_t f);
        tnn_pkg::hidden_vec_t h;
        int best;
        int best_c;
        h      = model_hidden(f);
        best   = class_score(h, 0);
        best_c = 0;
        for (int c = 1; c < `TNN_CLASS_CNT; c++) begin
            if (class_score(h, c) > best) begin  // first maximum wins.
                best   = class_score(h, c);
                best_c = c;
            end
        end
        return tnn_pkg::class_t'(best_c);
    endfunction

    // true when two or more classes share the top score.
    function automatic bit top_tie(input tnn_pkg::feature_vec_t f);
        tnn_pkg::hidden_vec_t h;
        int best;
        int hits;
        h    = model_hidden(f);
        best = -1;
        hits = 0;
        for (int c = 0; c < `TNN_CLASS_CNT; c++) begin
            if (class_score(h, c) > best) begin
                best = class_score(h, c);
                hits = 1;
            end else if (class_score(h, c) == best) begin
                hits++;
            end
        end
        return hits > 1;
    endfunction

    function automatic tnn_pkg::feature_vec_t random_vector();
        tnn_pkg::feature_vec_t v;
        for (int i = 0; i < `TNN_FEAT_CNT; i++) begin
            v[i] = tnn_pkg::feature_t'($urandom_range(15, 0));
        end
        return v;
    endfunction

    // **************************************************
    // drivers and result checker
    // **************************************************

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // leaves in_valid high so that calls can run back to back.
    task automatic send(input tnn_pkg::feature_vec_t v);
        features = v;
        in_valid = 1'b1;
        expected_q.push_back(predict(v));
        n_sent++;
        tick();
    endtask

    task automatic idle(input int n);
        in_valid = 1'b0;
        repeat (n) tick();
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        in_valid = 1'b0;
        while (expected_q.size() != 0) begin
            if (t >= WAIT_LIMIT) abort_run("timeout waiting for pending results");
            tick();
            t++;
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            assert (expected_q.size() > 0)
                else abort_run("out_valid seen with no input in flight");
            exp_cls = expected_q.pop_front();
            assert (prediction == exp_cls)
                else abort_run($sformatf("MISMATCH at %0t: prediction %0d, expected %0d",
                                         $time, prediction, exp_cls));
        end
    end

    // **************************************************
    // directed tests
    // **************************************************

    task automatic test_reset_state();
        assert (out_valid == 1'b0 && prediction == '0 && result_count == '0)
            else abort_run($sformatf("MISMATCH at %0t: outputs not cleared by reset", $time));
        repeat (12) begin
            tick();
            assert (out_valid == 1'b0)
                else abort_run($sformatf("MISMATCH at %0t: out_valid with no input", $time));
        end
    endtask

    task automatic test_single();
        int lat;
        for (int k = 0; k < 2; k++) begin
            send((k == 0) ? tnn_pkg::feature_vec_t'('0) : tnn_pkg::feature_vec_t'('1));
            in_valid = 1'b0;
            lat = 1;  // edges since the drive.
            while (!out_valid) begin
                if (lat >= WAIT_LIMIT) abort_run("timeout waiting for out_valid");
                tick();
                lat++;
            end
            assert (lat == `TNN_STAGES)
                else abort_run($sformatf("MISMATCH at %0t: latency %0d, expected %0d",
                                         $time, lat, `TNN_STAGES));
            wait_drain();
        end
    endtask

    task automatic test_ties();
        tnn_pkg::feature_vec_t v;
        int found;
        int tries;
        found = 0;
        tries = 0;
        while (found < 8) begin
            if (tries >= 5000) abort_run("search found too few vectors with tied scores");
            v = random_vector();
            tries++;
            if (top_tie(v)) begin
                send(v);
                idle(1);
                found++;
            end
        end
        wait_drain();
    endtask

    task automatic test_back_to_back();
        repeat (200) send(random_vector());
        wait_drain();
    endtask

    task automatic test_gapped();
        repeat (60) begin
            send(random_vector());
            idle($urandom_range(3, 0));
        end
        wait_drain();
        idle(10);  // checker fails on any stray out_valid.
    endtask

    task automatic test_count();
        wait_drain();
        assert (result_count == tnn_pkg::count_t'(n_sent))
            else abort_run($sformatf("MISMATCH at %0t: result_count %0d, expected %0d",
                                     $time, result_count, n_sent));
    endtask

    initial begin
        void'($urandom(59));
        clk      = 1'b0;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        features = '0;
        n_sent   = 0;
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        test_reset_state();
        test_single();
        test_ties();
        test_back_to_back();
        test_gapped();
        test_count();

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== tnn_classifier.f ====
+incdir+include
rtl/tnn_pkg.sv
rtl/tnn_ctrl.sv
rtl/tnn_hidden_layer.sv
rtl/tnn_output_layer.sv
rtl/tnn_argmax.sv
rtl/tnn_classifier_top.sv
bench/tnn_classifier_sva.sv
bench/tnn_classifier_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tnn_classifier.f --top-module tnn_classifier_tb -Mdir obj_dir

out=$(./obj_dir/Vtnn_classifier_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi
